// ==== dsnk_ctrl.f ====
common/dsnk_pkg.sv
common/dsnk_reg_wr_if.sv
axil/dsnk_axil_write.sv
axil/dsnk_axil_read.sv
hdl/dsnk_regs.sv
hdl/dsnk_if.sv
tests/tb_dsnk_if.sv

// ==== tests/tb_dsnk_if.sv ====
`timescale 1ns/1ns

module tb_dsnk_if;

  import dsnk_pkg::*;

  // Table size, also sets the watchdog limit
  localparam int NUM_TESTS = 26;
  localparam int CLK_PERIOD = 20;

  // One table row, exp is rdata for reads and the cmd port for writes
  typedef struct {
    string        name;
    bit           is_read;
    logic [4:0]   addr;
    word_t        data;
    strb_t        strb;
    int           hold;
    word_t        exp;
  } test_t;

  logic        S_AXI_ACLK;
  logic        S_AXI_ARESETN;
  logic [4:0]  awaddr;
  logic        awvalid;
  logic        awready;
  word_t       wdata;
  strb_t       wstrb;
  logic        wvalid;
  logic        wready;
  resp_t       bresp;
  logic        bvalid;
  logic        bready;
  logic [4:0]  araddr;
  logic        arvalid;
  logic        arready;
  word_t       rdata;
  resp_t       rresp;
  logic        rvalid;
  logic        rready;
  word_t       cmd;
  logic        new_cmd;
  word_t       stat;
  word_t       recv_bytes;
  logic [63:0] checksum;

  test_t       tests [NUM_TESTS];
  int          n_tests;
  int          errors;
  int          errs_before;
  int          passed;
  int          failed;
  int          pulses;
  int          exp_pulses;
  logic [31:0] lcg_state;
  word_t       cmd_model;
  word_t       scratch_model;
  word_t       got;
  resp_t       resp;

  dsnk_if uut (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .bresp         (bresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready),
    .cmd           (cmd),
    .new_cmd       (new_cmd),
    .stat          (stat),
    .recv_bytes    (recv_bytes),
    .checksum      (checksum)
  );

  //////////////////////////////////////////////////////////////////////
  // Clock, watchdog and new_cmd monitor

  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // Generous budget of 40 cycles per table row
  initial
  begin
    #(NUM_TESTS * 40 * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d ns", NUM_TESTS * 40 * CLK_PERIOD);
    $display("STATUS: FAIL");
    $finish;
  end

  // Sampled mid-cycle, a one-cycle pulse counts once
  always @(negedge S_AXI_ACLK)
  begin
    if (new_cmd)
      pulses = pulses + 1;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference helpers

  // Classic 32-bit LCG step
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // All-ones byte for every strobed lane
  function automatic word_t lane_mask(strb_t strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  // Read value per register map, holes read zero
  function automatic word_t expected_read(logic [2:0] idx);
    case (idx)
      3'd0: return cmd_model;
      3'd1: return stat;
      3'd2: return recv_bytes;
      3'd3: return checksum[63:32];
      3'd4: return checksum[31:0];
      3'd5: return scratch_model;
      default: return 32'h0;
    endcase
  endfunction

  // Append a row and advance the register model
  task automatic add_test(input string name, input bit is_read, input logic [4:0] addr,
                          input word_t data, input strb_t strb, input int hold);
    logic [2:0] idx;
    word_t      m;
    idx = addr[4:2];
    m = lane_mask(strb);
    tests[n_tests].name    = name;
    tests[n_tests].is_read = is_read;
    tests[n_tests].addr    = addr;
    tests[n_tests].data    = data;
    tests[n_tests].strb    = strb;
    tests[n_tests].hold    = hold;
    if (is_read)
      tests[n_tests].exp = expected_read(idx);
    else
    begin
      if (idx == 3'd0)
        cmd_model = (cmd_model & ~m) | (data & m);
      else if (idx == 3'd5)
        scratch_model = (scratch_model & ~m) | (data & m);
      tests[n_tests].exp = cmd_model;
    end
    n_tests = n_tests + 1;
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act)
    else
    begin
      $display("FAILED %s %s expected %h actual %h", name, what, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic report_test(input string name);
    if (errors == errs_before)
    begin
      passed = passed + 1;
      $display("test %-22s ok", name);
    end
    else
    begin
      failed = failed + 1;
      $display("test %-22s failed", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI4-Lite host tasks

  // With hold set, BREADY stays low and a second identical write waits behind it
  task automatic write_word(input logic [4:0] addr, input word_t data, input strb_t strb,
                            input int hold, output resp_t wresp);
    int rounds;
    rounds = (hold > 0) ? 2 : 1;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = (hold == 0);
    for (int r = 0; r < rounds; r++)
    begin
      // Ready seen mid-cycle, beats transfer on the next edge
      do @(negedge S_AXI_ACLK); while (!awready);
      assert (wready)
      else
      begin
        $display("Write data channel was not ready together with the address channel");
        errors = errors + 1;
      end
      @(negedge S_AXI_ACLK);
      if (r == rounds - 1)
      begin
        awvalid = 1'b0;
        wvalid  = 1'b0;
      end
      assert (bvalid)
      else
      begin
        $display("Write to %h was accepted but no response followed", addr);
        errors = errors + 1;
      end
      wresp = bresp;
      if (r == 0)
      begin
        repeat (hold)
        begin
          assert (bvalid && !awready && !wready)
          else
          begin
            $display("Write response dropped or a new write taken while BREADY was low");
            errors = errors + 1;
          end
          @(negedge S_AXI_ACLK);
        end
      end
      bready = 1'b1;
      @(negedge S_AXI_ACLK);
    end
    bready = 1'b0;
  endtask

  task automatic read_word(input logic [4:0] addr, input int hold,
                           output word_t data, output resp_t rd_resp);
    word_t stat_saved;
    stat_saved = stat;
    araddr  = addr;
    arvalid = 1'b1;
    rready  = (hold == 0);
    do @(negedge S_AXI_ACLK); while (!arready);
    @(negedge S_AXI_ACLK);
    arvalid = 1'b0;
    assert (rvalid)
    else
    begin
      $display("Read of %h was accepted but no data followed", addr);
      errors = errors + 1;
    end
    data    = rdata;
    rd_resp = rresp;
    // RDATA must hold while the host stalls, even with the status input moving
    repeat (hold)
    begin
      assert (rvalid && rdata === data)
      else
      begin
        $display("Read data changed or dropped while RREADY was low");
        errors = errors + 1;
      end
      stat = ~stat;
      @(negedge S_AXI_ACLK);
    end
    stat   = stat_saved;
    rready = 1'b1;
    @(negedge S_AXI_ACLK);
    rready = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus

  initial
  begin
    S_AXI_ARESETN = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    errors  = 0;
    passed  = 0;
    failed  = 0;
    pulses  = 0;
    exp_pulses    = 0;
    n_tests       = 0;
    cmd_model     = '0;
    scratch_model = '0;
    // Sink inputs stay fixed apart from the stalled read
    lcg_state  = 32'd59;
    stat       = lcg_next();
    recv_bytes = lcg_next();
    checksum   = {lcg_next(), lcg_next()};

    add_test("scratch_after_reset", 1'b1, 5'h14, 32'h0, 4'h0, 0);
    add_test("cmd_full_wr", 1'b0, 5'h00, 32'hA5C3_1E77, 4'hF, 0);
    add_test("cmd_full_rd", 1'b1, 5'h00, 32'h0, 4'h0, 0);
    add_test("cmd_lanes_0_2_wr", 1'b0, 5'h00, 32'h1122_3344, 4'b0101, 0);
    add_test("cmd_lanes_rd", 1'b1, 5'h00, 32'h0, 4'h0, 0);
    add_test("cmd_no_strobe_wr", 1'b0, 5'h00, 32'hFFFF_FFFF, 4'h0, 0);
    add_test("scratch_full_wr", 1'b0, 5'h14, 32'hDEAD_BEEF, 4'hF, 0);
    add_test("scratch_lane_1_wr", 1'b0, 5'h14, 32'h0000_5500, 4'b0010, 0);
    add_test("scratch_rd", 1'b1, 5'h14, 32'h0, 4'h0, 0);
    add_test("stat_rd", 1'b1, 5'h04, 32'h0, 4'h0, 0);
    add_test("recv_bytes_rd", 1'b1, 5'h08, 32'h0, 4'h0, 0);
    add_test("csum_hi_rd", 1'b1, 5'h0C, 32'h0, 4'h0, 0);
    add_test("csum_lo_rd", 1'b1, 5'h10, 32'h0, 4'h0, 0);
    add_test("stat_wr_ignored", 1'b0, 5'h04, 32'hFFFF_FFFF, 4'hF, 0);
    add_test("recv_bytes_wr_ignored", 1'b0, 5'h08, 32'hFFFF_FFFF, 4'hF, 0);
    add_test("csum_hi_wr_ignored", 1'b0, 5'h0C, 32'hFFFF_FFFF, 4'hF, 0);
    add_test("csum_lo_wr_ignored", 1'b0, 5'h10, 32'hFFFF_FFFF, 4'hF, 0);
    add_test("hole_6_wr_ignored", 1'b0, 5'h18, 32'hFFFF_FFFF, 4'hF, 0);
    add_test("hole_7_wr_ignored", 1'b0, 5'h1C, 32'hFFFF_FFFF, 4'hF, 0);
    add_test("cmd_after_ignored_rd", 1'b1, 5'h00, 32'h0, 4'h0, 0);
    add_test("scratch_after_ignored_rd", 1'b1, 5'h14, 32'h0, 4'h0, 0);
    add_test("hole_6_rd", 1'b1, 5'h18, 32'h0, 4'h0, 0);
    add_test("hole_7_rd", 1'b1, 5'h1C, 32'h0, 4'h0, 0);
    add_test("bready_hold_wr", 1'b0, 5'h14, 32'h0BAD_F00D, 4'hF, 5);
    add_test("scratch_after_hold_rd", 1'b1, 5'h14, 32'h0, 4'h0, 0);
    add_test("rready_hold_rd", 1'b1, 5'h04, 32'h0, 4'h0, 4);

    // Two clock cycles in reset
    repeat (2) @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    @(negedge S_AXI_ACLK);

    // Idle state before any access
    errs_before = errors;
    check_value("reset_state", "cmd", 32'h0, cmd);
    check_value("reset_state", "new_cmd", 32'h0, {31'h0, new_cmd});
    report_test("reset_state");

    for (int i = 0; i < n_tests; i++)
    begin
      errs_before = errors;
      if (tests[i].is_read)
      begin
        read_word(tests[i].addr, tests[i].hold, got, resp);
        check_value(tests[i].name, "rdata", tests[i].exp, got);
      end
      else
      begin
        write_word(tests[i].addr, tests[i].data, tests[i].strb, tests[i].hold, resp);
        // The held write is issued twice
        if (tests[i].addr[4:2] == 3'd0)
          exp_pulses = exp_pulses + ((tests[i].hold > 0) ? 2 : 1);
        check_value(tests[i].name, "cmd", tests[i].exp, cmd);
        check_value(tests[i].name, "new_cmd pulses", exp_pulses, pulses);
      end
      check_value(tests[i].name, "resp", {30'h0, RESP_OKAY}, {30'h0, resp});
      report_test(tests[i].name);
    end

    $display("tests passed %0d failed %0d", passed, failed);
    if (failed == 0 && errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== hdl/dsnk_if.sv ====
`timescale 1ns/1ns

module dsnk_if #(
  parameter int data_width = dsnk_pkg::DATA_WIDTH,
  parameter int addr_width = dsnk_pkg::ADDR_WIDTH
) (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // AXI4-Lite write address
  input  logic [addr_width-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  // AXI4-Lite write data
  input  dsnk_pkg::word_t       wdata,
  input  dsnk_pkg::strb_t       wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  // AXI4-Lite write response
  output dsnk_pkg::resp_t       bresp,
  output logic                  bvalid,
  input  logic                  bready,
  // AXI4-Lite read address
  input  logic [addr_width-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  // AXI4-Lite read data
  output dsnk_pkg::word_t       rdata,
  output dsnk_pkg::resp_t       rresp,
  output logic                  rvalid,
  input  logic                  rready,
  // Data sink
  output dsnk_pkg::word_t       cmd,
  output logic                  new_cmd,
  input  dsnk_pkg::word_t       stat,
  input  dsnk_pkg::word_t       recv_bytes,
  input  logic [63:0]           checksum
);

  import dsnk_pkg::*;

  // Read port between the AXI read side and the register file
  reg_index_t rd_index;
  word_t      rd_data;

  // Write strobes into the register file
  dsnk_reg_wr_if reg_wr ();

  //////////////////////////////////////////////////////////////////////
  // AXI channels

  dsnk_axil_write #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_write (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .awaddr        (awaddr),
    .awvalid       (awvalid),
    .awready       (awready),
    .wdata         (wdata),
    .wstrb         (wstrb),
    .wvalid        (wvalid),
    .wready        (wready),
    .bresp         (bresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .wr            (reg_wr.master)
  );

  dsnk_axil_read #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_read (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .araddr        (araddr),
    .arvalid       (arvalid),
    .arready       (arready),
    .rdata         (rdata),
    .rresp         (rresp),
    .rvalid        (rvalid),
    .rready        (rready),
    .rd_index      (rd_index),
    .rd_data       (rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // Register file

  dsnk_regs #(
    .data_width (data_width),
    .addr_width (addr_width)
  ) u_regs (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr            (reg_wr.slave),
    .rd_index      (rd_index),
    .rd_data       (rd_data),
    .stat          (stat),
    .recv_bytes    (recv_bytes),
    .checksum      (checksum),
    .cmd           (cmd),
    .new_cmd       (new_cmd)
  );

endmodule

// ==== hdl/dsnk_regs.sv ====
`timescale 1ns/1ns

module dsnk_regs #(
  parameter int data_width = dsnk_pkg::DATA_WIDTH,
  parameter int addr_width = dsnk_pkg::ADDR_WIDTH
) (
  input  logic                 S_AXI_ACLK,
  input  logic                 S_AXI_ARESETN,
  // Register write port
  dsnk_reg_wr_if.slave         wr,
  // Register read port
  input  dsnk_pkg::reg_index_t rd_index,
  output dsnk_pkg::word_t      rd_data,
  // Sink side
  input  dsnk_pkg::word_t      stat,
  input  dsnk_pkg::word_t      recv_bytes,
  input  logic [63:0]          checksum,
  output dsnk_pkg::word_t      cmd,
  output logic                 new_cmd
);

  import dsnk_pkg::*;

  // Writable words
  word_t cmd_q;
  word_t scratch_q;

  // Byte address must reach every word of the map
  if (addr_width < ADDR_LSB + $bits(reg_index_t))
  begin : g_addr_width_check
    $error("dsnk_regs: addr_width too small for the register map");
  end

  // Replace only the strobed byte lanes of a word
  function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
    word_t res;
    res = old_w;
    for (int lane = 0; lane < data_width / 8; lane++)
    begin
      if (strb[lane])
        res[lane*8 +: 8] = new_w[lane*8 +: 8];
    end
    return res;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Write side

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      cmd_q     <= '0;
      scratch_q <= '0;
      new_cmd   <= 1'b0;
    end
    else
    begin
      // Pulse on every command write, even with no strobes set
      new_cmd <= wr.wr_en && (wr.wr_index == REG_CMD);
      if (wr.wr_en)
      begin
        case (wr.wr_index)
          REG_CMD:     cmd_q     <= merge_bytes(cmd_q, wr.wr_data, wr.wr_strb);
          REG_SCRATCH: scratch_q <= merge_bytes(scratch_q, wr.wr_data, wr.wr_strb);
          // Read-only and unmapped words ignore writes
          default:     ;
        endcase
      end
    end
  end

  // Sink sees the command as soon as it lands
  assign cmd = cmd_q;

  //////////////////////////////////////////////////////////////////////
  // Read multiplexer

  always_comb
  begin
    case (rd_index)
      REG_CMD:        rd_data = cmd_q;
      REG_STAT:       rd_data = stat;
      REG_RECV_BYTES: rd_data = recv_bytes;
      REG_CSUM_HI:    rd_data = checksum[63:32];
      REG_CSUM_LO:    rd_data = checksum[31:0];
      REG_SCRATCH:    rd_data = scratch_q;
      // Holes in the map read as zero
      default:        rd_data = '0;
    endcase
  end

  // Write side never issues strobes back to back
  a_new_cmd_single : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    new_cmd |=> !new_cmd);

endmodule

// ==== axil/dsnk_axil_read.sv ====
`timescale 1ns/1ns

module dsnk_axil_read #(
  parameter int data_width = dsnk_pkg::DATA_WIDTH,
  parameter int addr_width = dsnk_pkg::ADDR_WIDTH
) (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // Read address channel
  input  logic [addr_width-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  // Read data channel
  output dsnk_pkg::word_t       rdata,
  output dsnk_pkg::resp_t       rresp,
  output logic                  rvalid,
  input  logic                  rready,
  // Register read port
  output dsnk_pkg::reg_index_t  rd_index,
  input  dsnk_pkg::word_t       rd_data
);

  import dsnk_pkg::*;

  // Captured word index of the read in flight
  reg_index_t index_q;

  // Read data is one package word wide
  if (data_width != $bits(word_t))
  begin : g_data_width_check
    $error("dsnk_axil_read: data_width must match word_t");
  end

  //////////////////////////////////////////////////////////////////////
  // Address capture

  // Index latched on the edge that raises arready
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!arready && arvalid && !rvalid)
      index_q <= araddr[ADDR_LSB +: $bits(reg_index_t)];
  end

  // Register file decodes the held index combinationally
  assign rd_index = index_q;

  //////////////////////////////////////////////////////////////////////
  // Read handshake and data

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rdata   <= '0;
    end
    else
    begin
      // One read in flight, no new address while data waits
      arready <= !arready && arvalid && !rvalid;
      if (arready && arvalid)
      begin
        // Address transfers here, load the selected word
        rvalid <= 1'b1;
        rdata  <= rd_data;
      end
      else if (rvalid && rready)
        rvalid <= 1'b0;
    end
  end

  // Every read, mapped or not, is OKAY
  assign rresp = RESP_OKAY;

  // Data must not move under a stalled host
  a_rdata_stable : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    rvalid && !rready |=> $stable(rdata));

endmodule

// ==== axil/dsnk_axil_write.sv ====
`timescale 1ns/1ns

module dsnk_axil_write #(
  parameter int data_width = dsnk_pkg::DATA_WIDTH,
  parameter int addr_width = dsnk_pkg::ADDR_WIDTH
) (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  // Write address channel
  input  logic [addr_width-1:0] awaddr,
  input  logic                  awvalid,
  output logic                  awready,
  // Write data channel
  input  dsnk_pkg::word_t       wdata,
  input  dsnk_pkg::strb_t       wstrb,
  input  logic                  wvalid,
  output logic                  wready,
  // Write response channel
  output dsnk_pkg::resp_t       bresp,
  output logic                  bvalid,
  input  logic                  bready,
  // Register write port
  dsnk_reg_wr_if.master         wr
);

  import dsnk_pkg::*;

  // Register words are fixed at the package word width
  if (data_width != $bits(word_t))
  begin : g_data_width_check
    $error("dsnk_axil_write: data_width must match word_t");
  end

  //////////////////////////////////////////////////////////////////////
  // Address and data handshake

  // Address and data are taken together, one write at a time
  // Ready goes high only while no response is pending
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      awready <= 1'b0;
      wready  <= 1'b0;
    end
    else
    begin
      if (!awready && awvalid && wvalid && !bvalid)
      begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      else
      begin
        // Single-cycle ready pulse
        awready <= 1'b0;
        wready  <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Register write strobe

  // Both beats transfer on the same edge
  assign wr.wr_en    = awready && awvalid && wready && wvalid;
  // Word index sits above the byte offset bits
  assign wr.wr_index = awaddr[ADDR_LSB +: $bits(reg_index_t)];
  assign wr.wr_data  = wdata;
  assign wr.wr_strb  = wstrb;

  //////////////////////////////////////////////////////////////////////
  // Write response

  // Pending from the accept edge until the host takes it
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      bvalid <= 1'b0;
    else if (wr.wr_en)
      bvalid <= 1'b1;
    else if (bvalid && bready)
      bvalid <= 1'b0;
  end

  // Unmapped and read-only words are still OKAY
  assign bresp = RESP_OKAY;

  // Response holds until the host is ready
  a_bvalid_hold : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    bvalid && !bready |=> bvalid);

  // Address and data channels always accept together
  a_ready_pair : assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    awready == wready);

endmodule

// ==== common/dsnk_reg_wr_if.sv ====
`timescale 1ns/1ns

// Register write port between the AXI write side and the register file
interface dsnk_reg_wr_if;

  import dsnk_pkg::*;

  // One-cycle write strobe, the register file never stalls it
  logic       wr_en;
  // Target word in the register map
  reg_index_t wr_index;
  // Write payload
  word_t      wr_data;
  // Byte lanes to update
  strb_t      wr_strb;

  // AXI write channel side
  modport master (
    output wr_en,
    output wr_index,
    output wr_data,
    output wr_strb
  );

  // Register file side
  modport slave (
    input wr_en,
    input wr_index,
    input wr_data,
    input wr_strb
  );

endinterface

// ==== common/dsnk_pkg.sv ====
package dsnk_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths

  // Default AXI4-Lite data width in bits
  localparam int DATA_WIDTH = 32;
  // Default byte address width, covers eight words
  localparam int ADDR_WIDTH = 5;

  // Byte offset bits below the word index
  localparam int ADDR_LSB = $clog2(DATA_WIDTH / 8);

  //////////////////////////////////////////////////////////////////////
  // Types

  // One register word
  typedef logic [DATA_WIDTH-1:0] word_t;
  // One strobe bit per byte lane
  typedef logic [DATA_WIDTH/8-1:0] strb_t;
  // Word index into the register map
  typedef logic [2:0] reg_index_t;
  // AXI response code
  typedef logic [1:0] resp_t;

  // Only OKAY is ever returned
  localparam resp_t RESP_OKAY = 2'b00;

  //////////////////////////////////////////////////////////////////////
  // Register map

  // Command word, writes raise new_cmd
  localparam reg_index_t REG_CMD = 3'd0;
  // Sink status, read only
  localparam reg_index_t REG_STAT = 3'd1;
  // Received byte count, read only
  localparam reg_index_t REG_RECV_BYTES = 3'd2;
  // Checksum upper and lower words, read only
  localparam reg_index_t REG_CSUM_HI = 3'd3;
  localparam reg_index_t REG_CSUM_LO = 3'd4;
  // Free scratch word for the host
  localparam reg_index_t REG_SCRATCH = 3'd5;

endpackage
